// File: Makefile
# Verilator build and run of the hazard unit testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the log holds the pass message"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module mipsHazardTb \
		-f mipsHazard.f -Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: mipsHazard.f
verilog/isaPkg.sv
verilog/hazardPkg.sv
verilog/useDecode.sv
verilog/destDecode.sv
verilog/issuePipe.sv
verilog/mdTimer.sv
verilog/mdSequencer.sv
verilog/stallCtrl.sv
verilog/mipsHazard.sv
tb/mipsHazard_assert.sv
tb/mipsHazardTb.sv

// File: tb/mipsHazardTb.sv
`timescale 1ns/10ps
`default_nettype none

module mipsHazardTb
	import isaPkg::*, hazardPkg::*;
();

	localparam int multCycles = 5;
	localparam int divCycles  = 10;
	localparam int waitLimit  = 40;

	localparam logic [5:0] aluFunct [6] = '{ADD, SUB, AND, OR, SLT, SLTU};
	localparam logic [5:0] immOps   [4] = '{ORI, ADDI, ANDI, LUI};
	localparam logic [5:0] loadOps  [3] = '{LW, LB, LH};
	localparam logic [5:0] storeOps [3] = '{SW, SB, SH};
	localparam logic [5:0] moveFunct[4] = '{MFHI, MFLO, MTHI, MTLO};
	localparam logic [5:0] mdFunct  [4] = '{MULT, MULTU, DIV, DIVU};

	logic        clk;
	logic        rstN;
	logic        instrValid;
	logic [31:0] instr;
	logic        instrReady;
	logic        stall;
	fwdSelT      fwdRsD;
	fwdSelT      fwdRtD;
	fwdSelT      fwdRsE;
	fwdSelT      fwdRtE;

	// Reference pipeline
	logic [31:0] modelD;
	logic [31:0] modelE;
	logic [31:0] modelM;
	logic [31:0] modelW;
	int          busyLeft;
	bit          modelLive = 1'b0;
	logic [31:0] sentQ[$];
	logic [31:0] acceptedQ[$];

	int          errors = 0;
	int          checks = 0;
	logic [3:0]  seenM = 4'd0;
	logic [3:0]  seenW = 4'd0;

	mipsHazard i_dut (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.instrReady (instrReady),
		.stall      (stall),
		.fwdRsD     (fwdRsD),
		.fwdRtD     (fwdRtD),
		.fwdRsE     (fwdRsE),
		.fwdRtE     (fwdRtE)
	);

	bind mipsHazard mipsHazardAssert uAssert (
		.clk        (clk),
		.rstN       (rstN),
		.stall      (stall),
		.instrD     (instrD),
		.fwdRsD     (fwdRsD),
		.fwdRtD     (fwdRtD),
		.fwdRsE     (fwdRsE),
		.fwdRtE     (fwdRtE),
		.mdState    (uMdSequencer.state),
		.timerCount (uMdSequencer.uTimer.count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// Reference tables
	//////////////////////////////

	// Source use and need time packed as {use, tuse}
	function automatic logic [2:0] needOf(logic [31:0] w, bit isRt);
		opcodeT     op;
		functT      fn;
		logic       u;
		logic [1:0] t;
		op = opcodeT'(w[OP_HI:OP_LO]);
		fn = functT'(w[FUNCT_HI:FUNCT_LO]);
		u = 1'b0;
		t = 2'd1;
		if (op == R) begin
			if (fn inside {ADD, SUB, AND, OR, SLT, SLTU, MULT, MULTU, DIV, DIVU}) begin
				u = 1'b1;
			end else if (fn inside {MTHI, MTLO}) begin
				u = !isRt;
			end else if (fn == JR) begin
				u = !isRt;
				t = 2'd0;
			end
		end else if (op inside {ORI, ADDI, ANDI, LW, LB, LH}) begin
			u = !isRt;
		end else if (op inside {SW, SB, SH}) begin
			u = 1'b1;
			t = isRt ? 2'd2 : 2'd1;
		end else if (op == BEQ) begin
			u = 1'b1;
			t = 2'd0;
		end
		return {u, t};
	endfunction

	// Destination and Tnew seen from execute packed as {dest, tnew}
	function automatic logic [6:0] prodOf(logic [31:0] w);
		opcodeT op;
		functT  fn;
		op = opcodeT'(w[OP_HI:OP_LO]);
		fn = functT'(w[FUNCT_HI:FUNCT_LO]);
		if (op == R && fn inside {ADD, SUB, AND, OR, SLT, SLTU, MFHI, MFLO})
			return {w[RD_HI:RD_LO], 2'd1};
		if (op inside {ORI, ADDI, ANDI, LUI})
			return {w[RT_HI:RT_LO], 2'd1};
		if (op inside {LW, LB, LH})
			return {w[RT_HI:RT_LO], 2'd2};
		if (op == JAL)
			return {5'd31, 2'd0};
		return 7'd0;
	endfunction

	function automatic bit isMdClass(logic [31:0] w);
		return opcodeT'(w[OP_HI:OP_LO]) == R &&
			functT'(w[FUNCT_HI:FUNCT_LO]) inside {MULT, MULTU, DIV, DIVU, MFHI, MFLO, MTHI, MTLO};
	endfunction

	function automatic bit startsMd(logic [31:0] w);
		return opcodeT'(w[OP_HI:OP_LO]) == R &&
			functT'(w[FUNCT_HI:FUNCT_LO]) inside {MULT, MULTU, DIV, DIVU};
	endfunction

	function automatic int mdLength(logic [31:0] w);
		return functT'(w[FUNCT_HI:FUNCT_LO]) inside {DIV, DIVU} ? divCycles : multCycles;
	endfunction

	function automatic bit tooLate(logic [4:0] src, logic [2:0] need,
			logic [4:0] dE, int tE, logic [4:0] dM, int tM);
		return need[2] && src != 5'd0 &&
			((src == dE && tE > int'(need[1:0])) || (src == dM && tM > int'(need[1:0])));
	endfunction

	function automatic fwdSelT fwdFor(logic [4:0] src, logic [4:0] dM, int tM, logic [4:0] dW);
		if (src == 5'd0)
			return FWD_RF;
		if (src == dM && tM == 0)
			return FWD_M;
		if (src == dW)
			return FWD_W;
		return FWD_RF;
	endfunction

	// Expected {stall, fwdRsD, fwdRtD, fwdRsE, fwdRtE} for one pipeline state
	function automatic logic [8:0] expectedOutputs(logic [31:0] d, logic [31:0] e,
			logic [31:0] m, logic [31:0] w, bit busy);
		logic [6:0] pe;
		logic [6:0] pm;
		logic [6:0] pw;
		int         tM;
		logic [4:0] rs;
		logic [4:0] rt;
		bit         stallNow;
		pe = prodOf(e);
		pm = prodOf(m);
		pw = prodOf(w);
		tM = int'(pm[1:0]) > 1 ? int'(pm[1:0]) - 1 : 0;
		rs = d[RS_HI:RS_LO];
		rt = d[RT_HI:RT_LO];
		stallNow = tooLate(rs, needOf(d, 1'b0), pe[6:2], int'(pe[1:0]), pm[6:2], tM) ||
			tooLate(rt, needOf(d, 1'b1), pe[6:2], int'(pe[1:0]), pm[6:2], tM) ||
			(isMdClass(d) && (busy || startsMd(e)));
		return {stallNow,
			fwdFor(rs, pm[6:2], tM, pw[6:2]), fwdFor(rt, pm[6:2], tM, pw[6:2]),
			fwdFor(e[RS_HI:RS_LO], pm[6:2], tM, pw[6:2]),
			fwdFor(e[RT_HI:RT_LO], pm[6:2], tM, pw[6:2])};
	endfunction

	//////////////////////////////
	// Model and compare
	//////////////////////////////
	always @(posedge clk) begin
		logic [8:0] want;
		if (!rstN) begin
			modelD = 32'd0;
			modelE = 32'd0;
			modelM = 32'd0;
			modelW = 32'd0;
			busyLeft = 0;
			modelLive = 1'b1;
		end else begin
			want = expectedOutputs(modelD, modelE, modelM, modelW, busyLeft != 0);
			if (startsMd(modelE))
				busyLeft = mdLength(modelE);
			else if (busyLeft > 0)
				busyLeft--;
			modelW = modelM;
			modelM = modelE;
			if (want[8]) begin
				modelE = 32'd0;
			end else begin
				modelE = modelD;
				modelD = instrValid ? instr : 32'd0;
				if (instrValid)
					acceptedQ.push_back(instr);
			end
		end
	end

	always @(negedge clk) begin
		logic [8:0] want;
		if (modelLive) begin
			want = expectedOutputs(modelD, modelE, modelM, modelW, busyLeft != 0);
			checkValue("stall", 32'(stall), 32'(want[8]));
			checkValue("instrReady", 32'(instrReady), 32'(!want[8]));
			checkValue("fwdRsD", 32'(fwdRsD), 32'(want[7:6]));
			checkValue("fwdRtD", 32'(fwdRtD), 32'(want[5:4]));
			checkValue("fwdRsE", 32'(fwdRsE), 32'(want[3:2]));
			checkValue("fwdRtE", 32'(fwdRtE), 32'(want[1:0]));
			checkValue("instrD", i_dut.instrD, modelD);
			seenM |= {fwdRtE == FWD_M, fwdRsE == FWD_M, fwdRtD == FWD_M, fwdRsD == FWD_M};
			seenW |= {fwdRtE == FWD_W, fwdRsE == FWD_W, fwdRtD == FWD_W, fwdRsD == FWD_W};
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[ERROR] %0d ns %s got %0h expected %0h", $time, name, got, want);
		end
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	function automatic logic [31:0] rType(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd);
		return {6'(R), rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] randomInstr();
		int          pick;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		pick = $urandom_range(99, 0);
		rs = 5'($urandom_range(7, 0));
		rt = 5'($urandom_range(7, 0));
		rd = 5'($urandom_range(7, 0));
		imm = 16'($urandom);
		if (pick < 30)
			return rType(aluFunct[$urandom_range(5, 0)], rs, rt, rd);
		if (pick < 45)
			return iType(immOps[$urandom_range(3, 0)], rs, rt, imm);
		if (pick < 60)
			return iType(loadOps[$urandom_range(2, 0)], rs, rt, imm);
		if (pick < 70)
			return iType(storeOps[$urandom_range(2, 0)], rs, rt, imm);
		if (pick < 78)
			return iType(BEQ, rs, rt, imm);
		if (pick < 82)
			return {(pick < 80) ? 6'(JAL) : 6'(J), 26'($urandom)};
		if (pick < 85)
			return rType(JR, rs, 5'd0, 5'd0);
		if (pick < 95)
			return rType(moveFunct[$urandom_range(3, 0)], rs, 5'd0, rd);
		return rType(mdFunct[$urandom_range(3, 0)], rs, rt, 5'd0);
	endfunction

	// Offer one word and hold it until decode takes it
	task automatic sendInstr(input logic [31:0] w);
		int waited;
		@(negedge clk);
		instrValid = 1'b1;
		instr = w;
		waited = 0;
		while (!instrReady && waited < waitLimit) begin
			@(negedge clk);
			waited++;
		end
		if (instrReady) begin
			sentQ.push_back(w);
		end else begin
			errors++;
			$display("Timeout: instruction %h was never accepted", w);
		end
	endtask

	task automatic idleCycle();
		@(negedge clk);
		instrValid = 1'b0;
		instr = $urandom;
	endtask

	task automatic drain();
		repeat (6) idleCycle();
	endtask

	task automatic countStalls(output int n);
		int waited;
		n = 0;
		waited = 0;
		idleCycle();
		while (stall && waited < waitLimit) begin
			n++;
			waited++;
			@(negedge clk);
		end
		if (stall) begin
			errors++;
			$display("Timeout: stall never cleared");
		end
	endtask

	initial begin
		int n;
		void'($urandom(32'hccc9));
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = 32'd0;
		repeat (3) @(negedge clk);
		rstN = 1'b1;

		// Values left by reset
		checkValue("stall", 32'(stall), 32'd0);
		checkValue("instrReady", 32'(instrReady), 32'd1);
		checkValue("fwd selects", 32'({fwdRsD, fwdRtD, fwdRsE, fwdRtE}), 32'd0);

		// Load-use
		sendInstr(iType(LW, 5'd1, 5'd2, 16'd0));
		sendInstr(rType(ADD, 5'd2, 5'd1, 5'd3));
		countStalls(n);
		checkValue("load-add stall cycles", 32'(n), 32'd1);
		drain();
		sendInstr(iType(LW, 5'd1, 5'd2, 16'd0));
		sendInstr(iType(BEQ, 5'd2, 5'd1, 16'd4));
		countStalls(n);
		checkValue("load-beq stall cycles", 32'(n), 32'd2);
		drain();

		// Forwarding from memory and writeback
		sendInstr(rType(ADD, 5'd1, 5'd2, 5'd3));
		idleCycle();
		sendInstr(rType(ADD, 5'd3, 5'd3, 5'd4));
		sendInstr(rType(ADD, 5'd1, 5'd2, 5'd5));
		sendInstr(rType(OR, 5'd5, 5'd5, 5'd6));
		sendInstr(rType(ADD, 5'd1, 5'd2, 5'd7));
		idleCycle();
		idleCycle();
		sendInstr(rType(SUB, 5'd7, 5'd7, 5'd1));
		sendInstr({6'(JAL), 26'd64});
		sendInstr(rType(ADD, 5'd31, 5'd31, 5'd2));
		// Register 0 is never forwarded
		sendInstr(iType(ORI, 5'd1, 5'd0, 16'd5));
		sendInstr(rType(ADD, 5'd0, 5'd0, 5'd2));
		drain();

		// Multiply/divide
		sendInstr(rType(DIV, 5'd1, 5'd2, 5'd0));
		sendInstr(rType(MFLO, 5'd0, 5'd0, 5'd3));
		countStalls(n);
		checkValue("mflo after div stall cycles", 32'(n), 32'(divCycles + 1));
		drain();
		sendInstr(rType(MULT, 5'd1, 5'd2, 5'd0));
		sendInstr(rType(MFLO, 5'd0, 5'd0, 5'd4));
		countStalls(n);
		checkValue("mflo after mult stall cycles", 32'(n), 32'(multCycles + 1));
		drain();

		// Words held at the input during stalls
		sendInstr(iType(LW, 5'd1, 5'd2, 16'd0));
		sendInstr(rType(ADD, 5'd2, 5'd2, 5'd3));
		sendInstr(rType(ADD, 5'd3, 5'd2, 5'd4));
		sendInstr(rType(MULTU, 5'd1, 5'd2, 5'd0));
		sendInstr(rType(MFHI, 5'd0, 5'd0, 5'd5));
		sendInstr(rType(ADD, 5'd5, 5'd1, 5'd6));
		drain();

		repeat (3000) begin
			if ($urandom_range(99, 0) < 15)
				idleCycle();
			else
				sendInstr(randomInstr());
		end
		drain();

		checkValue("accepted count", 32'(acceptedQ.size()), 32'(sentQ.size()));
		foreach (sentQ[i]) begin
			if (i < acceptedQ.size())
				checkValue("accepted instr", acceptedQ[i], sentQ[i]);
		end
		if (seenM != 4'hf || seenW != 4'hf) begin
			errors++;
			$display("Some forward select never chose memory or writeback");
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/mipsHazard_assert.sv
`timescale 1ns/10ps
`default_nettype none

module mipsHazardAssert
	import hazardPkg::*;
(
	input logic        clk,
	input logic        rstN,
	input logic        stall,
	input logic [31:0] instrD,
	input fwdSelT      fwdRsD,
	input fwdSelT      fwdRtD,
	input fwdSelT      fwdRsE,
	input fwdSelT      fwdRtE,
	input mdStateT     mdState,
	input logic [3:0]  timerCount
);

	// Reset clears every stage on the next edge
	resetQuiet: assert property (@(posedge clk)
		!rstN |=> (fwdRsD == FWD_RF && fwdRtD == FWD_RF && fwdRsE == FWD_RF && fwdRtE == FWD_RF))
		else $error("forward select other than register file during reset");

	holdDecode: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> $stable(instrD))
		else $error("instruction in decode changed during a stall");

	// Busy period is the timer's count
	busyTimer: assert property (@(posedge clk) disable iff (!rstN)
		mdState == MD_BUSY |-> timerCount != 4'd0)
		else $error("multiply/divide unit busy with the timer stopped");

endmodule

`default_nettype wire

// File: verilog/destDecode.sv
`timescale 1ns/10ps
`default_nettype none

module destDecode
	import isaPkg::*, hazardPkg::*;
#(
	parameter int stageDepth = 0
) (
	input  logic [31:0] instr,
	output logic [4:0]  dest,
	output stageTimeT   tnew
);

	opcodeT    op;
	functT     fn;
	stageTimeT tableTnew;

	assign op = opcodeT'(instr[OP_HI:OP_LO]);
	assign fn = functT'(instr[FUNCT_HI:FUNCT_LO]);

	//////////////////////////////
	// Production table, seen from execute
	//////////////////////////////
	always_comb begin
		dest      = 5'd0;
		tableTnew = 2'd0;
		case (op)
			R: begin
				case (fn)
					ADD, SUB, AND, OR, SLT, SLTU, MFHI, MFLO: begin
						dest      = instr[RD_HI:RD_LO];
						tableTnew = 2'd1;
					end
					default: ;
				endcase
			end
			ORI, ADDI, ANDI, LUI: begin
				dest      = instr[RT_HI:RT_LO];
				tableTnew = 2'd1;
			end
			LW, LB, LH: begin
				dest      = instr[RT_HI:RT_LO];
				tableTnew = 2'd2;
			end
			// Link register, known at once
			JAL: dest = 5'd31;
			default: ;
		endcase
	end

	// Each stage further down has that much less to wait
	always_comb begin
		if (int'(tableTnew) > stageDepth)
			tnew = stageTimeT'(int'(tableTnew) - stageDepth);
		else
			tnew = 2'd0;
	end

endmodule

`default_nettype wire

// File: verilog/hazardPkg.sv
`default_nettype none

package hazardPkg;

	// Cycles until an operand is needed (Tuse) or produced (Tnew)
	typedef logic [1:0] stageTimeT;

	// Where an operand takes its value from
	typedef enum logic [1:0] {
		FWD_RF = 2'd0,
		FWD_M  = 2'd1,
		FWD_W  = 2'd2
	} fwdSelT;

	// Multiply/divide unit
	typedef enum logic {
		MD_IDLE = 1'b0,
		MD_BUSY = 1'b1
	} mdStateT;

endpackage

`default_nettype wire

// File: verilog/isaPkg.sv
`default_nettype none

package isaPkg;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		R    = 6'h00,
		J    = 6'h02,
		JAL  = 6'h03,
		BEQ  = 6'h04,
		ADDI = 6'h08,
		ANDI = 6'h0c,
		ORI  = 6'h0d,
		LUI  = 6'h0f,
		LB   = 6'h20,
		LH   = 6'h21,
		LW   = 6'h23,
		SB   = 6'h28,
		SH   = 6'h29,
		SW   = 6'h2b
	} opcodeT;

	// Function codes under opcode R
	typedef enum logic [5:0] {
		JR    = 6'h08,
		MFHI  = 6'h10,
		MTHI  = 6'h11,
		MFLO  = 6'h12,
		MTLO  = 6'h13,
		MULT  = 6'h18,
		MULTU = 6'h19,
		DIV   = 6'h1a,
		DIVU  = 6'h1b,
		ADD   = 6'h20,
		SUB   = 6'h22,
		AND   = 6'h24,
		OR    = 6'h25,
		SLT   = 6'h2a,
		SLTU  = 6'h2b
	} functT;

	// Instruction field positions
	localparam int OP_HI    = 31;
	localparam int OP_LO    = 26;
	localparam int RS_HI    = 25;
	localparam int RS_LO    = 21;
	localparam int RT_HI    = 20;
	localparam int RT_LO    = 16;
	localparam int RD_HI    = 15;
	localparam int RD_LO    = 11;
	localparam int FUNCT_HI = 5;
	localparam int FUNCT_LO = 0;

endpackage

`default_nettype wire

// File: verilog/issuePipe.sv
`timescale 1ns/10ps
`default_nettype none

module issuePipe (
	input  logic        clk,
	input  logic        rstN,
	input  logic        stall,
	input  logic        instrValid,
	input  logic [31:0] instr,
	output logic [31:0] instrD,
	output logic [31:0] instrE,
	output logic [31:0] instrM,
	output logic [31:0] instrW
);

	// All-zero word travels as a nop
	localparam logic [31:0] bubble = 32'd0;

	//////////////////////////////
	// Decode and execute
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			instrD <= bubble;
			instrE <= bubble;
		end else if (stall) begin
			// Decode holds, execute gets a bubble
			instrE <= bubble;
		end else begin
			instrD <= instrValid ? instr : bubble;
			instrE <= instrD;
		end
	end

	//////////////////////////////
	// Memory and writeback never stop
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			instrM <= bubble;
			instrW <= bubble;
		end else begin
			instrM <= instrE;
			instrW <= instrM;
		end
	end

endmodule

`default_nettype wire

// File: verilog/mdSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module mdSequencer
	import isaPkg::*, hazardPkg::*;
#(
	parameter int multCycles = 5,
	parameter int divCycles  = 10
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] instrE,
	input  logic [31:0] instrD,
	output logic        mdStall
);

	localparam logic [3:0] multLoad = 4'(multCycles);
	localparam logic [3:0] divLoad  = 4'(divCycles);

	mdStateT    state;
	logic       startMd;
	logic       isDivE;
	logic       isMdD;
	logic       timerDone;
	logic [3:0] timerLoad;

	always_comb begin
		startMd = 1'b0;
		isDivE  = 1'b0;
		if (opcodeT'(instrE[OP_HI:OP_LO]) == R) begin
			case (functT'(instrE[FUNCT_HI:FUNCT_LO]))
				MULT, MULTU: startMd = 1'b1;
				DIV, DIVU: begin
					startMd = 1'b1;
					isDivE  = 1'b1;
				end
				default: ;
			endcase
		end
	end

	// Anything touching hi/lo waits on the unit
	always_comb begin
		isMdD = 1'b0;
		if (opcodeT'(instrD[OP_HI:OP_LO]) == R) begin
			case (functT'(instrD[FUNCT_HI:FUNCT_LO]))
				MULT, MULTU, DIV, DIVU, MFHI, MFLO, MTHI, MTLO: isMdD = 1'b1;
				default: ;
			endcase
		end
	end

	assign timerLoad = isDivE ? divLoad : multLoad;

	mdTimer uTimer (
		.clk       (clk),
		.rstN      (rstN),
		.load      (startMd),
		.loadValue (timerLoad),
		.done      (timerDone)
	);

	always_ff @(posedge clk) begin
		if (!rstN)
			state <= MD_IDLE;
		else if (startMd)
			state <= MD_BUSY;
		else if (timerDone)
			state <= MD_IDLE;
	end

	assign mdStall = isMdD && (state == MD_BUSY || startMd);

endmodule

`default_nettype wire

// File: verilog/mdTimer.sv
`timescale 1ns/10ps
`default_nettype none

module mdTimer (
	input  logic       clk,
	input  logic       rstN,
	input  logic       load,
	input  logic [3:0] loadValue,
	output logic       done
);

	logic [3:0] count;

	always_ff @(posedge clk) begin
		if (!rstN)
			count <= 4'd0;
		else if (load)
			count <= loadValue;
		else if (count != 4'd0)
			count <= count - 4'd1;
	end

	// Last busy cycle
	assign done = (count == 4'd1);

endmodule

`default_nettype wire

// File: verilog/mipsHazard.sv
`timescale 1ns/10ps
`default_nettype none

module mipsHazard
	import hazardPkg::*;
#(
	parameter int multCycles = 5,
	parameter int divCycles  = 10
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic        instrValid,
	input  logic [31:0] instr,
	output logic        instrReady,
	output logic        stall,
	output fwdSelT      fwdRsD,
	output fwdSelT      fwdRtD,
	output fwdSelT      fwdRsE,
	output fwdSelT      fwdRtE
);

	logic [31:0] instrD;
	logic [31:0] instrE;
	logic [31:0] instrM;
	logic [31:0] instrW;
	logic [4:0]  rsD;
	logic [4:0]  rtD;
	stageTimeT   tuseRs;
	stageTimeT   tuseRt;
	logic        useRs;
	logic        useRt;
	logic [4:0]  destE;
	logic [4:0]  destM;
	logic [4:0]  destW;
	stageTimeT   tnewE;
	stageTimeT   tnewM;
	logic        mdStall;

	//////////////////////////////
	// Shadow pipeline
	//////////////////////////////
	issuePipe uIssuePipe (
		.clk        (clk),
		.rstN       (rstN),
		.stall      (stall),
		.instrValid (instrValid),
		.instr      (instr),
		.instrD     (instrD),
		.instrE     (instrE),
		.instrM     (instrM),
		.instrW     (instrW)
	);

	assign instrReady = !stall;

	//////////////////////////////
	// Need and production times
	//////////////////////////////
	useDecode uUseDecode (
		.instrD (instrD),
		.rsD    (rsD),
		.rtD    (rtD),
		.tuseRs (tuseRs),
		.tuseRt (tuseRt),
		.useRs  (useRs),
		.useRt  (useRt)
	);

	destDecode #(.stageDepth(0)) uDestE (
		.instr (instrE),
		.dest  (destE),
		.tnew  (tnewE)
	);

	destDecode #(.stageDepth(1)) uDestM (
		.instr (instrM),
		.dest  (destM),
		.tnew  (tnewM)
	);

	// Everything in writeback is ready
	destDecode #(.stageDepth(2)) uDestW (
		.instr (instrW),
		.dest  (destW),
		.tnew  ()
	);

	mdSequencer #(
		.multCycles (multCycles),
		.divCycles  (divCycles)
	) uMdSequencer (
		.clk     (clk),
		.rstN    (rstN),
		.instrE  (instrE),
		.instrD  (instrD),
		.mdStall (mdStall)
	);

	stallCtrl uStallCtrl (
		.rsD     (rsD),
		.rtD     (rtD),
		.tuseRs  (tuseRs),
		.tuseRt  (tuseRt),
		.useRs   (useRs),
		.useRt   (useRt),
		.instrE  (instrE),
		.destE   (destE),
		.destM   (destM),
		.destW   (destW),
		.tnewE   (tnewE),
		.tnewM   (tnewM),
		.mdStall (mdStall),
		.stall   (stall),
		.fwdRsD  (fwdRsD),
		.fwdRtD  (fwdRtD),
		.fwdRsE  (fwdRsE),
		.fwdRtE  (fwdRtE)
	);

endmodule

`default_nettype wire

// File: verilog/stallCtrl.sv
`timescale 1ns/10ps
`default_nettype none

module stallCtrl
	import isaPkg::*, hazardPkg::*;
(
	input  logic [4:0]  rsD,
	input  logic [4:0]  rtD,
	input  stageTimeT   tuseRs,
	input  stageTimeT   tuseRt,
	input  logic        useRs,
	input  logic        useRt,
	input  logic [31:0] instrE,
	input  logic [4:0]  destE,
	input  logic [4:0]  destM,
	input  logic [4:0]  destW,
	input  stageTimeT   tnewE,
	input  stageTimeT   tnewM,
	input  logic        mdStall,
	output logic        stall,
	output fwdSelT      fwdRsD,
	output fwdSelT      fwdRtD,
	output fwdSelT      fwdRsE,
	output fwdSelT      fwdRtE
);

	logic stallRs;
	logic stallRt;

	// Pending value in E or M that arrives too late
	function automatic logic late(logic used, logic [4:0] src, stageTimeT tuse);
		late = used && src != 5'd0 &&
			((src == destE && tnewE > tuse) || (src == destM && tnewM > tuse));
	endfunction

	// Nearest ready producer wins, register 0 stays on the file
	function automatic fwdSelT pick(logic [4:0] src);
		if (src != 5'd0 && src == destM && tnewM == 2'd0)
			pick = FWD_M;
		else if (src != 5'd0 && src == destW)
			pick = FWD_W;
		else
			pick = FWD_RF;
	endfunction

	assign stallRs = late(useRs, rsD, tuseRs);
	assign stallRt = late(useRt, rtD, tuseRt);
	assign stall   = stallRs || stallRt || mdStall;

	assign fwdRsD = pick(rsD);
	assign fwdRtD = pick(rtD);
	assign fwdRsE = pick(instrE[RS_HI:RS_LO]);
	assign fwdRtE = pick(instrE[RT_HI:RT_LO]);

endmodule

`default_nettype wire

// File: verilog/useDecode.sv
`timescale 1ns/10ps
`default_nettype none

module useDecode
	import isaPkg::*, hazardPkg::*;
(
	input  logic [31:0] instrD,
	output logic [4:0]  rsD,
	output logic [4:0]  rtD,
	output stageTimeT   tuseRs,
	output stageTimeT   tuseRt,
	output logic        useRs,
	output logic        useRt
);

	opcodeT op;
	functT  fn;

	assign op  = opcodeT'(instrD[OP_HI:OP_LO]);
	assign fn  = functT'(instrD[FUNCT_HI:FUNCT_LO]);
	assign rsD = instrD[RS_HI:RS_LO];
	assign rtD = instrD[RT_HI:RT_LO];

	always_comb begin
		// Most sources are needed one cycle after decode
		useRs  = 1'b0;
		useRt  = 1'b0;
		tuseRs = 2'd1;
		tuseRt = 2'd1;
		case (op)
			R: begin
				case (fn)
					ADD, SUB, AND, OR, SLT, SLTU,
					MULT, MULTU, DIV, DIVU: begin
						useRs = 1'b1;
						useRt = 1'b1;
					end
					MTHI, MTLO: useRs = 1'b1;
					JR: begin
						useRs  = 1'b1;
						tuseRs = 2'd0;
					end
					default: ;
				endcase
			end
			ORI, ADDI, ANDI, LW, LB, LH: useRs = 1'b1;
			SW, SB, SH: begin
				// Store data is only needed in memory
				useRs  = 1'b1;
				useRt  = 1'b1;
				tuseRt = 2'd2;
			end
			BEQ: begin
				useRs  = 1'b1;
				useRt  = 1'b1;
				tuseRs = 2'd0;
				tuseRt = 2'd0;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire
